// File: rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, instruction bits 6 to 2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_ITYPE  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_RTYPE  = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10 // Immediate straight through for lui
  } alu_op_e;

  typedef enum logic [1:0] {
    PC_RESET    = 2'd0,
    PC_JAL      = 2'd1, // Jump target computed in D
    PC_PLUS4    = 2'd2,
    PC_REDIRECT = 2'd3  // ALU result from X
  } pc_sel_e;

  typedef enum logic [1:0] {
    WB_MEM = 2'd0,
    WB_ALU = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  typedef enum logic [2:0] {
    LDX_W  = 3'd0,
    LDX_HU = 3'd1,
    LDX_H  = 3'd2,
    LDX_BU = 3'd3,
    LDX_B  = 3'd4
  } ldx_e;

  typedef enum logic [1:0] {
    FWD_NONE   = 2'd0, // Register file or immediate
    FWD_WF_ALU = 2'd1,
    FWD_WF_MEM = 2'd2
  } fwd_sel_e;

  typedef enum logic [1:0] {
    A_RS1    = 2'd0,
    A_PC     = 2'd1,
    A_WF_MEM = 2'd2
  } a_sel_e;

  localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load funct3
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // Arithmetic funct3, shared by R-type and I-type
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // SRA when bit 30 set
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

endpackage

// File: inst_pipe.sv
`timescale 1ns/100ps

module inst_pipe (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush,
  input  rv_ctrl_pkg::instr_t d_instr,
  output rv_ctrl_pkg::instr_t x_instr,
  output rv_ctrl_pkg::instr_t wf_instr
);
  import rv_ctrl_pkg::*;

  // D to X register, a flush turns the wrong-path instruction into a bubble
  always_ff @(posedge clk) begin
    if (rst) begin
      x_instr <= NOP_INSTR;
    end else if (flush) begin
      x_instr <= NOP_INSTR;
    end else begin
      x_instr <= d_instr;
    end
  end

  // X to WF register
  always_ff @(posedge clk) begin
    if (rst) begin
      wf_instr <= NOP_INSTR;
    end else begin
      wf_instr <= x_instr;
    end
  end

endmodule

// File: decode_hazard.sv
`timescale 1ns/100ps

module decode_hazard (
  input  rv_ctrl_pkg::instr_t d_instr,
  input  rv_ctrl_pkg::instr_t wf_instr,
  output logic                d_fwd_a,
  output logic                d_fwd_b
);
  import rv_ctrl_pkg::*;

  opcode_e   wf_opc;
  reg_addr_t wf_rd;
  reg_addr_t d_rs1;
  reg_addr_t d_rs2;
  logic      wf_writes;

  assign wf_opc = opcode_e'(wf_instr[6:2]);
  assign wf_rd  = wf_instr[11:7];
  assign d_rs1  = d_instr[19:15];
  assign d_rs2  = d_instr[24:20];

  // Branches and stores carry no rd, x0 is never written
  assign wf_writes = (wf_opc != OP_BRANCH) && (wf_opc != OP_STORE) &&
                     (wf_rd != 5'd0);

  // WF writes the register file one cycle after D reads it
  assign d_fwd_a = wf_writes && (wf_rd == d_rs1); // Stale rs1 read
  assign d_fwd_b = wf_writes && (wf_rd == d_rs2); // Stale rs2 read

endmodule

// File: exec_ctrl.sv
`timescale 1ns/100ps

module exec_ctrl (
  input  logic                 rst,
  input  logic                 br_eq,
  input  logic                 br_lt,
  input  rv_ctrl_pkg::instr_t  x_instr,
  input  rv_ctrl_pkg::instr_t  d_instr,
  output rv_ctrl_pkg::alu_op_e alu_op,
  output logic                 b_sel,
  output logic                 br_un,
  output logic                 redirect,
  output rv_ctrl_pkg::pc_sel_e pc_sel
);
  import rv_ctrl_pkg::*;

  opcode_e    x_opc;
  opcode_e    d_opc;
  logic [2:0] x_f3;
  logic       x_alt;
  logic       br_taken;

  assign x_opc = opcode_e'(x_instr[6:2]);
  assign d_opc = opcode_e'(d_instr[6:2]);
  assign x_f3  = x_instr[14:12];
  assign x_alt = x_instr[30]; // funct7 bit selecting SUB and SRA

  always_comb begin
    alu_op = ALU_ADD; // Address and target arithmetic
    case (x_opc)
      OP_RTYPE, OP_ITYPE: begin
        case (x_f3)
          F3_ADD: begin
            if (x_opc == OP_RTYPE && x_alt) begin
              alu_op = ALU_SUB; // No subi in RV32I
            end else begin
              alu_op = ALU_ADD;
            end
          end
          F3_SLL:  alu_op = ALU_SLL;
          F3_SLT:  alu_op = ALU_SLT;
          F3_SLTU: alu_op = ALU_SLTU;
          F3_XOR:  alu_op = ALU_XOR;
          F3_SRL: begin
            if (x_alt) begin
              alu_op = ALU_SRA;
            end else begin
              alu_op = ALU_SRL;
            end
          end
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      OP_LUI:  alu_op = ALU_PASS_B;
      default: alu_op = ALU_ADD;
    endcase
  end

  assign b_sel = (x_opc != OP_RTYPE); // Immediate on B for all but R-type

  assign br_un = (x_opc == OP_BRANCH) && ((x_f3 == F3_BLTU) || (x_f3 == F3_BGEU));

  // Comparator flags belong to the X instruction's operands
  always_comb begin
    br_taken = 1'b0;
    if (x_opc == OP_BRANCH) begin
      case (x_f3)
        F3_BEQ:           br_taken = br_eq;
        F3_BNE:           br_taken = !br_eq;
        F3_BLT, F3_BLTU:  br_taken = br_lt;
        F3_BGE, F3_BGEU:  br_taken = !br_lt;
        default:          br_taken = 1'b0;
      endcase
    end
  end

  assign redirect = br_taken || (x_opc == OP_JALR);

  // A redirect flushes D, so a jal there must not steer the PC
  always_comb begin
    if (rst) begin
      pc_sel = PC_RESET;
    end else if (redirect) begin
      pc_sel = PC_REDIRECT;
    end else if (d_opc == OP_JAL) begin
      pc_sel = PC_JAL;
    end else begin
      pc_sel = PC_PLUS4;
    end
  end

endmodule

// File: operand_forward.sv
`timescale 1ns/100ps

module operand_forward (
  input  rv_ctrl_pkg::instr_t    x_instr,
  input  rv_ctrl_pkg::instr_t    wf_instr,
  output rv_ctrl_pkg::fwd_sel_e  fwd_a,
  output rv_ctrl_pkg::fwd_sel_e  fwd_b,
  output rv_ctrl_pkg::fwd_sel_e  rs2_sel,
  output rv_ctrl_pkg::a_sel_e    a_sel
);
  import rv_ctrl_pkg::*;

  opcode_e   x_opc;
  opcode_e   wf_opc;
  reg_addr_t x_rs1;
  reg_addr_t x_rs2;
  reg_addr_t wf_rd;
  logic      wf_writer;
  logic      wf_load;
  logic      hit_rs1;
  logic      hit_rs2;

  // Source of the forwarded value follows what WF is writing back
  function automatic fwd_sel_e fwd_pick(input logic hit, input logic is_load);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (hit) begin
      sel = is_load ? FWD_WF_MEM : FWD_WF_ALU;
    end
    return sel;
  endfunction

  assign x_opc  = opcode_e'(x_instr[6:2]);
  assign wf_opc = opcode_e'(wf_instr[6:2]);
  assign x_rs1  = x_instr[19:15];
  assign x_rs2  = x_instr[24:20];
  assign wf_rd  = wf_instr[11:7];

  assign wf_writer = (wf_opc != OP_BRANCH) && (wf_opc != OP_STORE) &&
                     (wf_rd != 5'd0);
  assign wf_load   = (wf_opc == OP_LOAD);

  assign hit_rs1 = wf_writer && (wf_rd == x_rs1);
  assign hit_rs2 = wf_writer && (wf_rd == x_rs2);

  assign fwd_a = fwd_pick(hit_rs1, wf_load);
  assign fwd_b = fwd_pick(hit_rs2, wf_load);

  // Store data path only
  assign rs2_sel = fwd_pick(hit_rs2 && (x_opc == OP_STORE), wf_load);

  always_comb begin
    if (x_opc == OP_BRANCH || x_opc == OP_JAL || x_opc == OP_AUIPC) begin
      a_sel = A_PC;
    end else if (x_opc == OP_STORE && wf_load && hit_rs1) begin
      a_sel = A_WF_MEM; // Load data as store base address
    end else begin
      a_sel = A_RS1;
    end
  end

endmodule

// File: wb_ctrl.sv
`timescale 1ns/100ps

module wb_ctrl (
  input  rv_ctrl_pkg::instr_t   wf_instr,
  output logic                  rf_we,
  output rv_ctrl_pkg::wb_sel_e  wb_sel,
  output rv_ctrl_pkg::ldx_e     ldx_sel
);
  import rv_ctrl_pkg::*;

  opcode_e    wf_opc;
  reg_addr_t  wf_rd;
  logic [2:0] wf_f3;

  assign wf_opc = opcode_e'(wf_instr[6:2]);
  assign wf_rd  = wf_instr[11:7];
  assign wf_f3  = wf_instr[14:12];

  always_comb begin
    case (wf_opc)
      OP_RTYPE, OP_ITYPE, OP_LOAD, OP_JAL, OP_JALR, OP_AUIPC, OP_LUI: rf_we = 1'b1;
      default: rf_we = 1'b0; // Store, branch and unknown
    endcase
    if (wf_rd == 5'd0) begin
      rf_we = 1'b0; // x0 is hardwired to zero
    end
  end

  always_comb begin
    case (wf_opc)
      OP_LOAD:         wb_sel = WB_MEM;
      OP_JAL, OP_JALR: wb_sel = WB_PC4; // Link address
      default:         wb_sel = WB_ALU;
    endcase
  end

  // Sign or zero extension of the loaded byte or half
  always_comb begin
    ldx_sel = LDX_W;
    if (wf_opc == OP_LOAD) begin
      case (wf_f3)
        F3_LB:   ldx_sel = LDX_B;
        F3_LH:   ldx_sel = LDX_H;
        F3_LW:   ldx_sel = LDX_W;
        F3_LBU:  ldx_sel = LDX_BU;
        F3_LHU:  ldx_sel = LDX_HU;
        default: ldx_sel = LDX_W;
      endcase
    end
  end

endmodule

// File: rv_ctrl_top.sv
`timescale 1ns/100ps

module rv_ctrl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  br_eq,
  input  logic                  br_lt,
  input  rv_ctrl_pkg::instr_t   d_instr,
  output rv_ctrl_pkg::pc_sel_e  pc_sel,
  output logic                  redirect,
  output logic                  d_fwd_a,
  output logic                  d_fwd_b,
  output rv_ctrl_pkg::alu_op_e  alu_op,
  output logic                  b_sel,
  output logic                  br_un,
  output rv_ctrl_pkg::a_sel_e   a_sel,
  output rv_ctrl_pkg::fwd_sel_e fwd_a,
  output rv_ctrl_pkg::fwd_sel_e fwd_b,
  output rv_ctrl_pkg::fwd_sel_e rs2_sel,
  output logic                  rf_we,
  output rv_ctrl_pkg::wb_sel_e  wb_sel,
  output rv_ctrl_pkg::ldx_e     ldx_sel
);
  import rv_ctrl_pkg::*;

  instr_t x_instr;
  instr_t wf_instr;

  inst_pipe u_inst_pipe (
    .clk      (clk),
    .rst      (rst),
    .flush    (redirect), // Bubble in place of the wrong-path D instruction
    .d_instr  (d_instr),
    .x_instr  (x_instr),
    .wf_instr (wf_instr)
  );

  decode_hazard u_decode_hazard (
    .d_instr  (d_instr),
    .wf_instr (wf_instr),
    .d_fwd_a  (d_fwd_a),
    .d_fwd_b  (d_fwd_b)
  );

  exec_ctrl u_exec_ctrl (
    .rst      (rst),
    .br_eq    (br_eq),
    .br_lt    (br_lt),
    .x_instr  (x_instr),
    .d_instr  (d_instr),
    .alu_op   (alu_op),
    .b_sel    (b_sel),
    .br_un    (br_un),
    .redirect (redirect),
    .pc_sel   (pc_sel)
  );

  operand_forward u_operand_forward (
    .x_instr  (x_instr),
    .wf_instr (wf_instr),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .rs2_sel  (rs2_sel),
    .a_sel    (a_sel)
  );

  wb_ctrl u_wb_ctrl (
    .wf_instr (wf_instr),
    .rf_we    (rf_we),
    .wb_sel   (wb_sel),
    .ldx_sel  (ldx_sel)
  );

endmodule

// File: rv_ctrl_props.sv
`timescale 1ns/100ps

module rv_ctrl_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  br_eq,
  input logic                  br_lt,
  input rv_ctrl_pkg::instr_t   d_instr,
  input rv_ctrl_pkg::pc_sel_e  pc_sel,
  input logic                  redirect,
  input logic                  d_fwd_a,
  input logic                  d_fwd_b,
  input rv_ctrl_pkg::alu_op_e  alu_op,
  input logic                  b_sel,
  input logic                  br_un,
  input rv_ctrl_pkg::a_sel_e   a_sel,
  input rv_ctrl_pkg::fwd_sel_e fwd_a,
  input rv_ctrl_pkg::fwd_sel_e fwd_b,
  input rv_ctrl_pkg::fwd_sel_e rs2_sel,
  input logic                  rf_we,
  input rv_ctrl_pkg::wb_sel_e  wb_sel,
  input rv_ctrl_pkg::ldx_e     ldx_sel
);
  import rv_ctrl_pkg::*;

  int         fail_count = 0;
  instr_t     m_x;          // Expected X stage content
  instr_t     m_wf;         // Expected WF stage content
  logic [4:0] x_op;
  logic [4:0] wf_op;
  logic [2:0] x_f3;
  logic       taken;
  logic       exp_redirect;
  logic       exp_we;
  logic       wf_writer;
  logic       hit_a;
  logic       hit_b;
  fwd_sel_e   wf_src;
  pc_sel_e    exp_pc;
  alu_op_e    exp_alu;
  a_sel_e     exp_a_sel;
  wb_sel_e    exp_wb;
  ldx_e       exp_ldx;

  task automatic count_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      m_x  <= NOP_INSTR;
      m_wf <= NOP_INSTR;
    end else begin
      m_x  <= exp_redirect ? NOP_INSTR : d_instr; // Flushed slot becomes a bubble
      m_wf <= m_x;
    end
  end

  assign x_op         = m_x[6:2];
  assign wf_op        = m_wf[6:2];
  assign x_f3         = m_x[14:12];
  assign exp_redirect = (x_op == OP_JALR) || (x_op == OP_BRANCH && taken);
  assign exp_pc       = exp_redirect ? PC_REDIRECT :
                        (d_instr[6:2] == OP_JAL) ? PC_JAL : PC_PLUS4;
  assign exp_we       = (wf_op inside {OP_RTYPE, OP_ITYPE, OP_LOAD, OP_JAL, OP_JALR,
                                       OP_AUIPC, OP_LUI}) && (m_wf[11:7] != 5'd0);
  assign wf_writer    = !(wf_op inside {OP_BRANCH, OP_STORE}) && (m_wf[11:7] != 5'd0);
  assign hit_a        = wf_writer && (m_wf[11:7] == m_x[19:15]);
  assign hit_b        = wf_writer && (m_wf[11:7] == m_x[24:20]);
  assign wf_src       = (wf_op == OP_LOAD) ? FWD_WF_MEM : FWD_WF_ALU;

  always_comb begin
    case (x_f3)
      F3_BEQ:          taken = br_eq;
      F3_BNE:          taken = !br_eq;
      F3_BLT, F3_BLTU: taken = br_lt;
      F3_BGE, F3_BGEU: taken = !br_lt;
      default:         taken = 1'b0; // Unused branch codes
    endcase
    exp_alu = ALU_ADD;
    if (x_op == OP_LUI) begin
      exp_alu = ALU_PASS_B;
    end else if (x_op inside {OP_RTYPE, OP_ITYPE}) begin
      case (x_f3)
        F3_ADD:  exp_alu = (m_x[30] && x_op == OP_RTYPE) ? ALU_SUB : ALU_ADD;
        F3_SLL:  exp_alu = ALU_SLL;
        F3_SLT:  exp_alu = ALU_SLT;
        F3_SLTU: exp_alu = ALU_SLTU;
        F3_XOR:  exp_alu = ALU_XOR;
        F3_SRL:  exp_alu = m_x[30] ? ALU_SRA : ALU_SRL;
        F3_OR:   exp_alu = ALU_OR;
        default: exp_alu = ALU_AND;
      endcase
    end
    exp_a_sel = A_RS1;
    if (x_op inside {OP_BRANCH, OP_JAL, OP_AUIPC}) begin
      exp_a_sel = A_PC;
    end else if (x_op == OP_STORE && hit_a && wf_op == OP_LOAD) begin
      exp_a_sel = A_WF_MEM;
    end
    case (wf_op)
      OP_LOAD:         exp_wb = WB_MEM;
      OP_JAL, OP_JALR: exp_wb = WB_PC4;
      default:         exp_wb = WB_ALU;
    endcase
    exp_ldx = LDX_W;
    if (wf_op == OP_LOAD) begin
      case (m_wf[14:12])
        F3_LB:   exp_ldx = LDX_B;
        F3_LH:   exp_ldx = LDX_H;
        F3_LBU:  exp_ldx = LDX_BU;
        F3_LHU:  exp_ldx = LDX_HU;
        default: exp_ldx = LDX_W;
      endcase
    end
  end

  a_reset_pc: assert property (@(posedge clk) rst |-> pc_sel == PC_RESET)
    else count_failure("pc_sel is not PC_RESET during reset");
  a_reset_exit: assert property (@(posedge clk) $past(rst) && !rst |-> !rf_we && !redirect &&
      fwd_a == FWD_NONE && fwd_b == FWD_NONE && rs2_sel == FWD_NONE)
    else count_failure("control outputs not idle on the first cycle after reset");
  a_wb: assert property (@(posedge clk) disable iff (rst)
      rf_we == exp_we && wb_sel == exp_wb && ldx_sel == exp_ldx)
    else count_failure("writeback selects disagree with the WF instruction");
  a_exec: assert property (@(posedge clk) disable iff (rst) alu_op == exp_alu &&
      b_sel == (x_op != OP_RTYPE) && br_un == (x_op == OP_BRANCH && x_f3[2:1] == 2'b11))
    else count_failure("ALU controls disagree with the X instruction");
  a_next_pc: assert property (@(posedge clk) disable iff (rst)
      redirect == exp_redirect && pc_sel == exp_pc)
    else count_failure("redirect or pc_sel wrong");
  // X operands take the WF result only from a real writer
  a_forward: assert property (@(posedge clk) disable iff (rst)
      fwd_a == (hit_a ? wf_src : FWD_NONE) && fwd_b == (hit_b ? wf_src : FWD_NONE) &&
      rs2_sel == ((hit_b && x_op == OP_STORE) ? wf_src : FWD_NONE) && a_sel == exp_a_sel)
    else count_failure("X-stage forwarding selects wrong");
  a_decode: assert property (@(posedge clk) disable iff (rst)
      d_fwd_a == (wf_writer && m_wf[11:7] == d_instr[19:15]) &&
      d_fwd_b == (wf_writer && m_wf[11:7] == d_instr[24:20]))
    else count_failure("D-stage hazard flags wrong");

endmodule

bind rv_ctrl_top rv_ctrl_props u_props (.*);

// File: tb_rv_ctrl.sv
`timescale 1ns/100ps

module tb_rv_ctrl;
  import rv_ctrl_pkg::*;

  logic     clk;
  logic     rst;
  logic     br_eq;
  logic     br_lt;
  instr_t   d_instr;
  pc_sel_e  pc_sel;
  logic     redirect;
  logic     d_fwd_a;
  logic     d_fwd_b;
  alu_op_e  alu_op;
  logic     b_sel;
  logic     br_un;
  a_sel_e   a_sel;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  fwd_sel_e rs2_sel;
  logic     rf_we;
  wb_sel_e  wb_sel;
  ldx_e     ldx_sel;

  integer   seed = 32'h10b6_dab3;
  int       errors = 0;
  int       waited;
  opcode_e  legal_ops [9] = '{OP_RTYPE, OP_ITYPE, OP_LOAD, OP_STORE, OP_BRANCH,
                              OP_JAL, OP_JALR, OP_AUIPC, OP_LUI};

  rv_ctrl_top dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Register fields limited to x0..x3 so hazards are frequent
  task automatic drive_random_instr();
    logic [31:0] r;
    int          idx;
    r       = $random(seed);
    idx     = $unsigned($random(seed)) % 9;
    d_instr = {1'b0, r[0], 8'd0, r[2:1], 3'd0, r[4:3], r[7:5],
               3'd0, r[9:8], legal_ops[idx], 2'b11};
    br_eq   = r[10];
    br_lt   = r[11];
  endtask

  initial begin
    rst     = 1'b1;
    br_eq   = 1'b0;
    br_lt   = 1'b0;
    d_instr = NOP_INSTR;
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (pc_sel !== PC_RESET) begin
      errors++;
      $display("mismatch at %0t: pc_sel %0d while in reset", $time, pc_sel);
    end
    rst = 1'b0;
    drive_random_instr();
    #10;
    if (rf_we !== 1'b0 || redirect !== 1'b0 || fwd_a !== FWD_NONE ||
        fwd_b !== FWD_NONE || rs2_sel !== FWD_NONE) begin
      errors++;
      $display("mismatch at %0t: control outputs not idle after reset", $time);
    end
    // Reach the flush path before the long run
    waited = 0;
    while (redirect !== 1'b1 && waited < 200) begin
      @(negedge clk);
      drive_random_instr();
      #10;
      waited++;
    end
    if (redirect !== 1'b1) begin
      errors++;
      $display("Timed out after %0d cycles waiting for a redirect", waited);
    end
    repeat (2000) begin
      @(negedge clk);
      drive_random_instr();
    end
    @(negedge clk);
    $display("Errors: %0d testbench, %0d assertion", errors, dut.u_props.fail_count);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: build.f
rv_ctrl_pkg.sv
inst_pipe.sv
decode_hazard.sv
exec_ctrl.sv
operand_forward.sv
wb_ctrl.sv
rv_ctrl_top.sv
rv_ctrl_props.sv
tb_rv_ctrl.sv
